// File: cpuCore.f
+incdir+.
cpuPkg.sv
ctrlPkg.sv
regFile.sv
alu.sv
shiftUnit.sv
stepCounter.sv
controlFsm.sv
cpuCore.sv
cpuCore_tb.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
TOP_RTL    = cpuCore
TOP_TB     = cpuCore_tb
FILE_LIST  = cpuCore.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP_RTL)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP_TB) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP_TB) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cpuCoreModel.svh
`ifndef CPU_CORE_MODEL_SVH
`define CPU_CORE_MODEL_SVH

// Expected copy of the sixteen registers
word_t mirror [16];

function automatic void clearMirror();
	mirror = '{default: '0};
endfunction

function automatic instr_t makeInstr(input logic [3:0] op, input regIdx_t rd,
	input regIdx_t ra, input regIdx_t rb);
	return instr_t'({op, rd, ra, rb});
endfunction

// Immediate sits in the ra and rb fields
function automatic instr_t makeLdi(input regIdx_t rd, input logic [7:0] imm);
	return makeInstr(OpLdi, rd, imm[7:4], imm[3:0]);
endfunction

////////////////////
// Expected behavior
////////////////////

function automatic word_t expectResult(input instr_t ins);
	word_t a;
	word_t b;
	a = mirror[ins.ra];
	b = mirror[ins.rb];
	case (ins.opcode)
		OpAdd:   return a + b;
		OpSub:   return a - b;
		OpAnd:   return a & b;
		OpOr:    return a | b;
		OpXor:   return a ^ b;
		// Zero-extended 8-bit immediate
		OpLdi:   return {8'h00, ins.ra, ins.rb};
		OpShl:   return a << ins.rb;
		OpShr:   return a >> ins.rb;
		default: return '0;
	endcase
endfunction

function automatic bit writesReg(input instr_t ins);
	case (ins.opcode)
		OpAdd, OpSub, OpAnd, OpOr, OpXor, OpLdi, OpShl, OpShr: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// Cycles from the strobe cycle to the done cycle
function automatic int expectLatency(input instr_t ins);
	if ((ins.opcode == OpShl) || (ins.opcode == OpShr))
	begin
		return 2 + int'(ins.rb);
	end
	return 2;
endfunction

function automatic void applyWrite(input instr_t ins, input word_t value);
	if (writesReg(ins))
	begin
		mirror[ins.rd] = value;
	end
endfunction

`endif

// File: cpuCore_tb.sv
`default_nettype none

module cpuCore_tb;

	import cpuPkg::*;

	localparam int ClkPeriod   = 20;
	localparam int ResetCycles = 10;
	localparam int DriveDelay  = 2;
	localparam int AluOps      = 40;
	// Reset reads, LDI fill, ALU, shifts, busy strobe, chain
	localparam int TotalInstr   = 16 + 32 + (AluOps + 6) + 32 + 33 + 9;
	localparam int WatchdogTime = (TotalInstr * 20 + ResetCycles) * ClkPeriod;

	// Instruction in flight and the cycle of its strobe
	typedef struct packed {
		instr_t ins;
		int     issueCycle;
	} pending_t;

	logic   Clk;
	logic   rstN;
	instr_t instr;
	logic   instrValid;
	logic   busy;
	logic   done;
	word_t  result;
	logic   zero;

	pending_t pending [$];
	int seed           = 8799;
	int cycleCount     = 0;
	int lastIssueCycle = 0;
	int lastDoneCycle  = 0;
	int checkCount     = 0;
	int errorCount     = 0;
	int checkBase      = 0;
	int errorBase      = 0;

	`include "cpuCoreModel.svh"

	cpuCore cpuCore_inst (
		.Clk        (Clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.busy       (busy),
		.done       (done),
		.result     (result),
		.zero       (zero)
	);

	initial
	begin
		Clk = 1'b0;
		forever
		begin
			#(ClkPeriod / 2);
			Clk = ~Clk;
		end
	end

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	initial
	begin
		#(WatchdogTime);
		$display("Error at %0t: run did not complete in time", $time);
		$display("SIMULATION FAILED");
		$finish;
	end

	////////////////////
	// Compare process
	////////////////////

	initial
	begin
		pending_t entry;
		word_t    expected;
		int       latency;
		forever
		begin
			@(negedge Clk);
			if (rstN && done)
			begin
				checkCount++;
				if (pending.size() == 0)
				begin
					$display("Error at %0t: done pulse with no instruction in flight", $time);
					errorCount++;
				end
				else
				begin
					entry = pending.pop_front();
					expected = expectResult(entry.ins);
					latency = cycleCount - entry.issueCycle;
					lastDoneCycle = cycleCount;
					if (result !== expected)
					begin
						$display("mismatch at %0t: result expected %h got %h",
							$time, expected, result);
						errorCount++;
					end
					if (zero !== (expected == '0))
					begin
						$display("mismatch at %0t: zero expected %b got %b",
							$time, (expected == '0), zero);
						errorCount++;
					end
					if (latency != expectLatency(entry.ins))
					begin
						$display("Error at %0t: done came %0d cycles after the strobe, not %0d",
							$time, latency, expectLatency(entry.ins));
						errorCount++;
					end
					applyWrite(entry.ins, expected);
				end
			end
		end
	end

	////////////////////
	// Driver tasks
	////////////////////

	// Called a drive delay after a rising edge
	task automatic issue(input instr_t ins);
		pending_t entry;
		while (busy !== 1'b0)
		begin
			@(posedge Clk);
			#DriveDelay;
		end
		instr = ins;
		instrValid = 1'b1;
		lastIssueCycle = cycleCount;
		entry.ins = ins;
		entry.issueCycle = cycleCount;
		pending.push_back(entry);
		@(posedge Clk);
		#DriveDelay;
		instrValid = 1'b0;
	endtask

	// Holds the strobe for as long as the core stays busy
	task automatic strobeWhileBusy(input instr_t ins);
		if (busy !== 1'b1)
		begin
			$display("Error at %0t: core idle where a busy strobe was due", $time);
			errorCount++;
		end
		while (busy === 1'b1)
		begin
			instr = ins;
			instrValid = 1'b1;
			@(posedge Clk);
			#DriveDelay;
		end
		instrValid = 1'b0;
	endtask

	// OR of a register with itself leaves it unchanged
	task automatic readReg(input regIdx_t idx);
		issue(makeInstr(OpOr, idx, idx, idx));
	endtask

	task automatic issueChained(input instr_t ins);
		issue(ins);
		if (lastIssueCycle != lastDoneCycle + 1)
		begin
			$display("Error at %0t: issued %0d cycles after the last done instead of 1",
				$time, lastIssueCycle - lastDoneCycle);
			errorCount++;
		end
	endtask

	task automatic waitDrain();
		while ((pending.size() != 0) || (busy !== 1'b0))
		begin
			@(posedge Clk);
			#DriveDelay;
		end
	endtask

	task automatic finishTest(input string name);
		waitDrain();
		$display("Test %s: %0d checks, %0d errors", name,
			checkCount - checkBase, errorCount - errorBase);
		checkBase = checkCount;
		errorBase = errorCount;
	endtask

	function automatic logic [3:0] aluCode(input logic [2:0] sel);
		case (sel)
			3'd0, 3'd5: return OpAdd;
			3'd1, 3'd6: return OpSub;
			3'd2:       return OpAnd;
			3'd3:       return OpOr;
			default:    return OpXor;
		endcase
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		logic [31:0] r;
		clearMirror();
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		repeat (ResetCycles) @(posedge Clk);
		#DriveDelay;
		rstN = 1'b1;

		// Quiet outputs before the first strobe
		repeat (3)
		begin
			@(negedge Clk);
			checkCount++;
			if (busy !== 1'b0)
			begin
				$display("mismatch at %0t: busy expected 0 got %b", $time, busy);
				errorCount++;
			end
			if (done !== 1'b0)
			begin
				$display("mismatch at %0t: done expected 0 got %b", $time, done);
				errorCount++;
			end
		end
		@(posedge Clk);
		#DriveDelay;

		for (int i = 0; i < 16; i++)
		begin
			readReg(4'(i));
		end
		finishTest("reset read-back");

		for (int i = 0; i < 16; i++)
		begin
			r = $random(seed);
			issue(makeLdi(4'(i), r[7:0]));
		end
		for (int i = 0; i < 16; i++)
		begin
			readReg(4'(i));
		end
		finishTest("LDI fill");

		// Two results that must raise zero
		issue(makeInstr(OpXor, 4'd3, 4'd5, 4'd5));
		issue(makeInstr(OpSub, 4'd4, 4'd4, 4'd4));
		// Borrow below zero, then carry out of bit 15 back to zero
		issue(makeLdi(4'd10, 8'h01));
		issue(makeInstr(OpSub, 4'd9, 4'd3, 4'd10));
		issue(makeInstr(OpAdd, 4'd9, 4'd9, 4'd10));
		issue(makeInstr(OpAdd, 4'd11, 4'd9, 4'd9));
		repeat (AluOps)
		begin
			r = $random(seed);
			issue(makeInstr(aluCode(r[14:12]), r[3:0], r[7:4], r[11:8]));
		end
		finishTest("random ALU");

		for (int amt = 0; amt < 16; amt++)
		begin
			r = $random(seed);
			issue(makeInstr(OpShl, r[3:0], r[7:4], 4'(amt)));
			r = $random(seed);
			issue(makeInstr(OpShr, r[3:0], r[7:4], 4'(amt)));
		end
		finishTest("shift sweep");

		// Long shift with a competing LDI held on the strobe
		issue(makeInstr(OpShl, 4'd1, 4'd2, 4'd9));
		strobeWhileBusy(makeLdi(4'd6, ~mirror[6][7:0]));
		// Nonzero targets, so a stray write of zero shows on read-back
		for (int c = 7; c < 15; c++)
		begin
			issue(makeLdi(4'(c), 8'h80 | 8'(c)));
		end
		issue(makeInstr(OpNop, 4'd7, 4'd7, 4'd7));
		for (int c = 8; c < 15; c++)
		begin
			issue(makeInstr(4'(c), 4'(c), 4'(c - 7), 4'(c - 8)));
		end
		for (int i = 0; i < 16; i++)
		begin
			readReg(4'(i));
		end
		finishTest("busy strobe and NOP");

		r = $random(seed);
		issueChained(makeLdi(4'd2, r[7:0]));
		issueChained(makeInstr(OpAdd, 4'd3, 4'd2, 4'd2));
		issueChained(makeInstr(OpSub, 4'd4, 4'd3, 4'd2));
		issueChained(makeInstr(OpOr, 4'd4, 4'd4, 4'd4));
		issueChained(makeInstr(OpShr, 4'd5, 4'd4, 4'd3));
		issueChained(makeInstr(OpXor, 4'd6, 4'd5, 4'd4));
		issueChained(makeInstr(OpOr, 4'd6, 4'd6, 4'd6));
		issueChained(makeInstr(OpShl, 4'd7, 4'd6, 4'd1));
		issueChained(makeInstr(OpAnd, 4'd8, 4'd7, 4'd7));
		finishTest("back-to-back");

		$display("Total: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cpuCore.sv
`default_nettype none

module cpuCore (
	input  logic           Clk,
	input  logic           rstN,
	input  cpuPkg::instr_t instr,
	input  logic           instrValid,
	output logic           busy,
	output logic           done,
	output cpuPkg::word_t  result,
	output logic           zero
);

	import cpuPkg::*;
	import ctrlPkg::*;

	ctrl_t   ctrl;
	regIdx_t rdIdx;
	regIdx_t raIdx;
	regIdx_t rbIdx;
	word_t   imm;
	word_t   readA;
	word_t   readB;
	word_t   operandB;
	word_t   aluResult;
	word_t   shiftResult;
	logic    lastStep;

	////////////////////
	// Control
	////////////////////

	controlFsm controlFsm_inst (
		.Clk        (Clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.lastStep   (lastStep),
		.ctrl       (ctrl),
		.rdIdx      (rdIdx),
		.raIdx      (raIdx),
		.rbIdx      (rbIdx),
		.imm        (imm),
		.busy       (busy),
		.done       (done)
	);

	// Shift amount comes from the rb field
	stepCounter stepCounter_inst (
		.Clk      (Clk),
		.rstN     (rstN),
		.load     (ctrl.shiftLoad),
		.count    (shamt_t'(rbIdx)),
		.dec      (ctrl.shiftStep),
		.lastStep (lastStep)
	);

	////////////////////
	// Datapath
	////////////////////

	regFile regFile_inst (
		.Clk       (Clk),
		.rstN      (rstN),
		.writeEn   (ctrl.regWrite),
		.writeIdx  (rdIdx),
		.readIdxA  (raIdx),
		.readIdxB  (rbIdx),
		.writeData (result),
		.readA     (readA),
		.readB     (readB)
	);

	// Immediate replaces register B for LDI
	assign operandB = ctrl.useImm ? imm : readB;

	alu alu_inst (
		.op (ctrl.aluOp),
		.a  (readA),
		.b  (operandB),
		.y  (aluResult)
	);

	shiftUnit shiftUnit_inst (
		.Clk       (Clk),
		.rstN      (rstN),
		.load      (ctrl.shiftLoad),
		.step      (ctrl.shiftStep),
		.left      (ctrl.shiftLeft),
		.loadValue (readA),
		.value     (shiftResult)
	);

	// Result bus, also the write-back data
	always_comb
	begin
		case (ctrl.resultSel)
			ResAlu:   result = aluResult;
			ResShift: result = shiftResult;
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: controlFsm.sv
`default_nettype none

module controlFsm (
	input  logic            Clk,
	input  logic            rstN,
	input  cpuPkg::instr_t  instr,
	input  logic            instrValid,
	input  logic            lastStep,
	output ctrlPkg::ctrl_t  ctrl,
	output cpuPkg::regIdx_t rdIdx,
	output cpuPkg::regIdx_t raIdx,
	output cpuPkg::regIdx_t rbIdx,
	output cpuPkg::word_t   imm,
	output logic            busy,
	output logic            done
);

	import cpuPkg::*;
	import ctrlPkg::*;

	typedef enum logic [1:0] {
		Idle,
		Execute,
		Shift,
		Writeback
	} state_t;

	state_t     state;
	state_t     nextState;
	instr_t     instrQ;
	imm8_t      immByte;
	aluOp_t     decAluOp;
	resultSel_t decResult;
	logic       decUseImm;
	logic       decShift;
	logic       decWrites;

	////////////////////
	// Instruction latch
	////////////////////

	always_ff @(posedge Clk)
	begin
		if ((state == Idle) && instrValid)
		begin
			instrQ <= instr;
		end
	end

	assign rdIdx   = instrQ.rd;
	assign raIdx   = instrQ.ra;
	assign rbIdx   = instrQ.rb;
	assign immByte = {instrQ.ra, instrQ.rb};
	assign imm     = word_t'(immByte);

	////////////////////
	// Decode
	////////////////////

	always_comb
	begin
		decUseImm = 1'b0;
		decShift  = 1'b0;
		decWrites = 1'b0;
		decResult = ResZero;
		case (instrQ.opcode)
			OpAdd, OpSub, OpAnd, OpOr, OpXor:
			begin
				decResult = ResAlu;
				decWrites = 1'b1;
			end
			OpLdi:
			begin
				decResult = ResAlu;
				decWrites = 1'b1;
				decUseImm = 1'b1;
			end
			OpShl, OpShr:
			begin
				decResult = ResShift;
				decWrites = 1'b1;
				decShift  = 1'b1;
			end
			default:
			begin
				// NOP and undefined codes
				decResult = ResZero;
			end
		endcase
	end

	always_comb
	begin
		case (instrQ.opcode)
			OpSub:   decAluOp = AluSub;
			OpAnd:   decAluOp = AluAnd;
			OpOr:    decAluOp = AluOr;
			OpXor:   decAluOp = AluXor;
			OpLdi:   decAluOp = AluPassB;
			default: decAluOp = AluAdd;
		endcase
	end

	////////////////////
	// State sequencing
	////////////////////

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			state <= Idle;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			Idle:
			begin
				if (instrValid)
				begin
					nextState = Execute;
				end
			end
			Execute:
			begin
				// Zero-length shift skips straight to writeback
				if (decShift && !lastStep)
				begin
					nextState = Shift;
				end
				else
				begin
					nextState = Writeback;
				end
			end
			Shift:
			begin
				if (lastStep)
				begin
					nextState = Writeback;
				end
			end
			default:
			begin
				nextState = Idle;
			end
		endcase
	end

	// Datapath controls
	always_comb
	begin
		ctrl.aluOp     = decAluOp;
		ctrl.useImm    = decUseImm;
		ctrl.shiftLeft = (instrQ.opcode == OpShl);
		ctrl.resultSel = decResult;
		ctrl.shiftLoad = (state == Execute) && decShift;
		ctrl.shiftStep = (state == Shift);
		ctrl.regWrite  = (state == Writeback) && decWrites;
	end

	assign busy = (state != Idle);
	assign done = (state == Writeback);

endmodule

`default_nettype wire

// File: stepCounter.sv
`default_nettype none

module stepCounter (
	input  logic           Clk,
	input  logic           rstN,
	input  logic           load,
	input  cpuPkg::shamt_t count,
	input  logic           dec,
	output logic           lastStep
);

	import cpuPkg::*;

	shamt_t remaining;
	shamt_t nextRemaining;

	// Steps left once this cycle completes
	always_comb
	begin
		nextRemaining = remaining;
		if (load)
		begin
			nextRemaining = count;
		end
		else if (dec && (remaining != '0))
		begin
			nextRemaining = remaining - 1'b1;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			remaining <= '0;
		end
		else
		begin
			remaining <= nextRemaining;
		end
	end

	// High on load of zero, or on the final step
	assign lastStep = (nextRemaining == '0);

endmodule

`default_nettype wire

// File: shiftUnit.sv
`default_nettype none

module shiftUnit (
	input  logic          Clk,
	input  logic          rstN,
	input  logic          load,
	input  logic          step,
	input  logic          left,
	input  cpuPkg::word_t loadValue,
	output cpuPkg::word_t value
);

	// Working register, one bit per step
	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			value <= '0;
		end
		else if (load)
		begin
			value <= loadValue;
		end
		else if (step)
		begin
			// Logical shift, vacated bit is zero
			if (left)
			begin
				value <= value << 1;
			end
			else
			begin
				value <= value >> 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
	input  ctrlPkg::aluOp_t op,
	input  cpuPkg::word_t   a,
	input  cpuPkg::word_t   b,
	output cpuPkg::word_t   y
);

	import ctrlPkg::*;

	// Arithmetic wraps at 16 bits
	always_comb
	begin
		case (op)
			AluAdd:
			begin
				y = a + b;
			end
			AluSub:
			begin
				y = a - b;
			end
			AluAnd:
			begin
				y = a & b;
			end
			AluOr:
			begin
				y = a | b;
			end
			AluXor:
			begin
				y = a ^ b;
			end
			AluPassB:
			begin
				// LDI immediate arrives on b
				y = b;
			end
			default:
			begin
				y = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: regFile.sv
`default_nettype none

module regFile (
	input  logic            Clk,
	input  logic            rstN,
	input  logic            writeEn,
	input  cpuPkg::regIdx_t writeIdx,
	input  cpuPkg::regIdx_t readIdxA,
	input  cpuPkg::regIdx_t readIdxB,
	input  cpuPkg::word_t   writeData,
	output cpuPkg::word_t   readA,
	output cpuPkg::word_t   readB
);

	import cpuPkg::*;

	// Register storage
	word_t regs [RegCount];

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < RegCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEn)
		begin
			// Only the addressed register changes
			regs[writeIdx] <= writeData;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Combinational, so a same-cycle write is not yet visible
	assign readA = regs[readIdxA];
	assign readB = regs[readIdxB];

endmodule

`default_nettype wire

// File: ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	// ALU function select
	typedef enum logic [2:0] {
		AluAdd   = 3'd0,
		AluSub   = 3'd1,
		AluAnd   = 3'd2,
		AluOr    = 3'd3,
		AluXor   = 3'd4,
		AluPassB = 3'd5
	} aluOp_t;

	// Source of the result bus, zero for NOP
	typedef enum logic [1:0] {
		ResAlu   = 2'd0,
		ResShift = 2'd1,
		ResZero  = 2'd2
	} resultSel_t;

	// Datapath controls from the FSM
	typedef struct packed {
		aluOp_t     aluOp;
		logic       useImm;
		logic       shiftLoad;
		logic       shiftStep;
		logic       shiftLeft;
		resultSel_t resultSel;
		logic       regWrite;
	} ctrl_t;

endpackage

`default_nettype wire

// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Sizes fixed by the instruction format
	localparam int WordBits = 16;
	localparam int RegCount = 16;
	localparam int IdxBits  = $clog2(RegCount);

	// Data word and register index
	typedef logic [WordBits-1:0] word_t;
	typedef logic [IdxBits-1:0]  regIdx_t;

	// Shift distance, 0 to 15
	typedef logic [3:0] shamt_t;

	// LDI immediate before zero extension
	typedef logic [7:0] imm8_t;

	// Any code not listed behaves as NOP
	typedef enum logic [3:0] {
		OpAdd = 4'h0,
		OpSub = 4'h1,
		OpAnd = 4'h2,
		OpOr  = 4'h3,
		OpXor = 4'h4,
		OpLdi = 4'h5,
		OpShl = 4'h6,
		OpShr = 4'h7,
		OpNop = 4'hF
	} opcode_t;

	////////////////////
	// Instruction word
	////////////////////

	// LDI takes {ra, rb} as immediate, shifts take rb as the amount
	typedef struct packed {
		opcode_t opcode;
		regIdx_t rd;
		regIdx_t ra;
		regIdx_t rb;
	} instr_t;

endpackage

`default_nettype wire
